// ==== files.f ====
+incdir+.
cpu_pkg.sv
fetch_unit.sv
instr_decoder.sv
reg_file.sv
alu.sv
processor.sv
tb_processor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_processor
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
EXTRA     ?=

VFLAGS = --timing --assert --top-module $(TOP) -f $(FILELIST) $(EXTRA)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qxF '=== PASS ===' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam logic [5:0] RTYPE_FN [13] = '{`CPU_FN_ADD, `CPU_FN_SUB, `CPU_FN_MUL,
  `CPU_FN_SLL, `CPU_FN_SRL, `CPU_FN_SLLV, `CPU_FN_SRLV, `CPU_FN_AND, `CPU_FN_OR,
  `CPU_FN_XOR, `CPU_FN_NOR, `CPU_FN_SLT, `CPU_FN_SLTU};
localparam logic [5:0] ITYPE_OP [6] = '{`CPU_OP_ADDI, `CPU_OP_SLTI, `CPU_OP_SLTIU,
  `CPU_OP_ANDI, `CPU_OP_ORI, `CPU_OP_XORI};

logic [31:0]      model_regs [32];
logic [31:0]      model_pc;
cpu_pkg::retire_t exp_q [$];
bit               exp_res_q [$];   // Result only defined for ALU instructions

// Instruction word for the current fetch address
function automatic cpu_pkg::instr_u gen_instr(input int unsigned idx);
  cpu_pkg::instr_u w;
  logic [31:0]     r, tgt, diff;
  int unsigned     pick;
  r    = lcg_next();
  w    = lcg_next();
  tgt  = {20'h0, r[11:2], 2'b00};   // 4 KB target window
  diff = tgt - (model_pc + 32'd4);
  pick = (r >> 16) % 100;
  if (idx < 16) begin
    // Seed r1 to r16
    w.i.opcode = idx[0] ? `CPU_OP_ORI : `CPU_OP_ADDI;
    w.i.rs     = '0;
    w.i.rt     = idx[4:0] + 5'd1;
  end else if (pick < 3) begin
    w.r.opcode = r[13] ? 6'h23 : 6'h03;   // lw, jal
    if (r[14]) begin
      w.r.opcode = `CPU_OP_RTYPE;
      w.r.funct  = 6'h08;                 // jr
    end
  end else if (pick < 48) begin
    w.r.opcode = `CPU_OP_RTYPE;
    w.r.funct  = RTYPE_FN[4'(pick % 13)];
  end else if (pick < 78) begin
    w.i.opcode = ITYPE_OP[3'(pick % 6)];
  end else if (pick < 93) begin
    w.i.opcode = r[12] ? `CPU_OP_BEQ : `CPU_OP_BNE;
    w.i.imm    = diff[17:2];
    if (r[13]) w.i.rt = w.i.rs;   // Forces equal operands
  end else begin
    w.j.opcode = `CPU_OP_J;
    w.j.target = tgt[27:2];
  end
  return w;
endfunction

// Executes one accepted word, queues its record and moves the model pc
task automatic execute_instr(input cpu_pkg::instr_u w);
  cpu_pkg::retire_t rec;
  logic [31:0]      rs_v, rt_v, sext, zext, seq, next_pc;
  logic [4:0]       dest;
  logic             alu_instr;
  logic             legal;
  rs_v      = model_regs[w.r.rs];
  rt_v      = model_regs[w.r.rt];
  sext      = {{16{w.i.imm[15]}}, w.i.imm};
  zext      = {16'h0, w.i.imm};
  seq       = model_pc + 32'd4;
  next_pc   = seq;
  rec       = '0;
  dest      = w.i.rt;
  alu_instr = 1'b1;
  legal     = 1'b1;
  case (w.r.opcode)
    `CPU_OP_RTYPE: begin
      dest = w.r.rd;
      case (w.r.funct)
        `CPU_FN_ADD:  rec.result = rs_v + rt_v;
        `CPU_FN_SUB:  rec.result = rs_v - rt_v;
        `CPU_FN_MUL:  rec.result = {16'h0, rs_v[15:0]} * {16'h0, rt_v[15:0]};
        `CPU_FN_SLL:  rec.result = rt_v << w.r.shamt;
        `CPU_FN_SRL:  rec.result = rt_v >> w.r.shamt;
        `CPU_FN_SLLV: rec.result = rt_v << rs_v[4:0];
        `CPU_FN_SRLV: rec.result = rt_v >> rs_v[4:0];
        `CPU_FN_AND:  rec.result = rs_v & rt_v;
        `CPU_FN_OR:   rec.result = rs_v | rt_v;
        `CPU_FN_XOR:  rec.result = rs_v ^ rt_v;
        `CPU_FN_NOR:  rec.result = ~(rs_v | rt_v);
        `CPU_FN_SLT:  rec.result = 32'($signed(rs_v) < $signed(rt_v));
        `CPU_FN_SLTU: rec.result = 32'(rs_v < rt_v);
        default:      legal = 1'b0;
      endcase
    end
    `CPU_OP_ADDI:  rec.result = rs_v + sext;
    `CPU_OP_SLTI:  rec.result = 32'($signed(rs_v) < $signed(sext));
    `CPU_OP_SLTIU: rec.result = 32'(rs_v < sext);
    `CPU_OP_ANDI:  rec.result = rs_v & zext;
    `CPU_OP_ORI:   rec.result = rs_v | zext;
    `CPU_OP_XORI:  rec.result = rs_v ^ zext;
    `CPU_OP_BEQ, `CPU_OP_BNE: begin
      alu_instr = 1'b0;
      if ((rs_v == rt_v) == (w.r.opcode == `CPU_OP_BEQ)) begin
        next_pc = seq + {sext[29:0], 2'b00};
      end
    end
    `CPU_OP_J: begin
      alu_instr = 1'b0;
      next_pc   = {seq[31:28], w.j.target, 2'b00};
    end
    default: legal = 1'b0;
  endcase
  alu_instr   = alu_instr && legal;
  rec.pc      = model_pc;
  rec.instr   = w;
  rec.reg_wr  = alu_instr && (dest != 5'd0);
  rec.wr_addr = alu_instr ? dest : 5'd0;
  rec.illegal = !legal;
  if (rec.reg_wr) model_regs[dest] = rec.result;
  exp_q.push_back(rec);
  exp_res_q.push_back(alu_instr);
  model_pc = next_pc;
endtask

`endif

// ==== tb_processor.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module tb_processor;

  localparam int N_INSTR     = 2000;
  localparam int CYCLE_LIMIT = N_INSTR * 8;

  logic                 clk;
  logic                 rst_n;
  cpu_pkg::instr_u      instr;
  logic                 instr_valid;
  logic                 instr_ready;
  logic [`CPU_XLEN-1:0] fetch_pc;
  cpu_pkg::retire_t     retire;
  logic                 retire_valid;
  logic                 retire_ready;

  logic [31:0] lcg_state = 32'hd2d0d017;
  int          errors;
  int          checks;
  int          cycles;
  int          retired;
  int unsigned n_issued;
  logic        holding;   // Word presented, not yet accepted

  processor dut (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic chance(input int unsigned pct);
    logic [31:0] r;
    r = lcg_next();
    return ({16'h0, r[31:16]} % 32'd100) < pct;
  endfunction

  `include "tb_isa_model.svh"

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("error: %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  // Compares the DUT against the model before the coming edge
  task automatic check_outputs();
    cpu_pkg::retire_t want;
    logic             held;
    held = exp_q.size() != 0;
    check_value("fetch_pc", fetch_pc, model_pc);
    check_value("retire_valid", 32'(retire_valid), 32'(held));
    check_value("instr_ready", 32'(instr_ready), 32'(!(held && !retire_ready)));
    if (retire_valid && held) begin
      want = exp_q[0];
      check_value("retire.pc", retire.pc, want.pc);
      check_value("retire.instr", retire.instr, want.instr);
      if (exp_res_q[0]) check_value("retire.result", retire.result, want.result);
      check_value("retire.reg_wr", 32'(retire.reg_wr), 32'(want.reg_wr));
      check_value("retire.wr_addr", 32'(retire.wr_addr), 32'(want.wr_addr));
      check_value("retire.illegal", 32'(retire.illegal), 32'(want.illegal));
      if (retire_ready) begin
        void'(exp_q.pop_front());
        void'(exp_res_q.pop_front());
        retired++;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_n        = 1'b0;
    instr        = '0;
    instr_valid  = 1'b0;
    retire_ready = 1'b0;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    retired      = 0;
    n_issued     = 0;
    holding      = 1'b0;
    model_pc     = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (10) begin
      @(negedge clk);
      check_outputs();   // Empty model, so reset values expected
    end
    rst_n = 1'b1;

    while ((n_issued < N_INSTR || holding || exp_q.size() != 0) && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (!holding) begin
        instr_valid = 1'b0;
        if (n_issued < N_INSTR && chance(70)) begin
          instr       = gen_instr(n_issued);
          instr_valid = 1'b1;
          holding     = 1'b1;
          n_issued++;
        end
      end
      retire_ready = chance(60);
      #1;
      check_outputs();
      if (instr_valid && instr_ready) begin
        execute_instr(instr);
        holding = 1'b0;
      end
    end

    if (n_issued < N_INSTR || holding || exp_q.size() != 0) begin
      errors++;
      $display("timeout after %0d cycles with %0d records still expected",
               cycles, exp_q.size());
    end
    $display("checks %0d, errors %0d, retired %0d of %0d, cycles %0d",
             checks, errors, retired, N_INSTR, cycles);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== processor.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module processor (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpu_pkg::instr_u      instr,
  input  logic                 instr_valid,
  output logic                 instr_ready,
  output logic [`CPU_XLEN-1:0] fetch_pc,
  output cpu_pkg::retire_t     retire,
  output logic                 retire_valid,
  input  logic                 retire_ready
);

  cpu_pkg::ctrl_t       ctrl;
  logic                 accept;
  logic [`CPU_XLEN-1:0] rs_data;
  logic [`CPU_XLEN-1:0] rt_data;
  logic [`CPU_XLEN-1:0] alu_a;
  logic [`CPU_XLEN-1:0] alu_b;
  logic [`CPU_XLEN-1:0] alu_result;
  logic                 rs_eq_rt;

  // One record in flight
  assign instr_ready = ~retire_valid | retire_ready;
  assign accept      = instr_valid & instr_ready;
  assign rs_eq_rt    = (rs_data == rt_data);

  fetch_unit u_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .accept   (accept),
    .instr    (instr),
    .ctrl     (ctrl),
    .rs_eq_rt (rs_eq_rt),
    .fetch_pc (fetch_pc)
  );

  instr_decoder u_dec (
    .instr (instr),
    .ctrl  (ctrl)
  );

  reg_file u_rf (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (instr.r.rs),
    .rt_addr (instr.r.rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (accept & ctrl.reg_wr),   // Write back at the accepting edge
    .wr_addr (ctrl.wr_addr),
    .wr_data (alu_result)
  );

  always_comb begin
    if (ctrl.src_imm) begin
      alu_a = rs_data;
      alu_b = ctrl.imm_value;
    end else if (ctrl.src_shamt) begin
      alu_a = rt_data;
      alu_b = {{(`CPU_XLEN-5){1'b0}}, instr.r.shamt};
    end else if (ctrl.shift_var) begin
      alu_a = rt_data;
      alu_b = rs_data;
    end else begin
      alu_a = rs_data;
      alu_b = rt_data;
    end
  end

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else if (accept) begin
      retire_valid <= 1'b1;
    end else if (retire_ready) begin
      retire_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      retire.pc      <= fetch_pc;
      retire.instr   <= instr;
      retire.result  <= alu_result;
      retire.reg_wr  <= ctrl.reg_wr;
      retire.wr_addr <= ctrl.wr_addr;
      retire.illegal <= ctrl.illegal;
    end
  end

  // Source holds the word until it is taken
  a_instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid && !instr_ready |=> instr_valid && $stable(instr));

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module alu (
  input  cpu_pkg::alu_op_e     op,
  input  logic [`CPU_XLEN-1:0] a,
  input  logic [`CPU_XLEN-1:0] b,
  output logic [`CPU_XLEN-1:0] result
);

  logic [4:0]           shamt;
  logic [`CPU_XLEN-1:0] a_lo;
  logic [`CPU_XLEN-1:0] b_lo;

  assign shamt = b[4:0];
  // 16x16 product, full 32 bits kept
  assign a_lo  = {{(`CPU_XLEN-16){1'b0}}, a[15:0]};
  assign b_lo  = {{(`CPU_XLEN-16){1'b0}}, b[15:0]};

  always_comb begin
    case (op)
      cpu_pkg::ALU_ADD:  result = a + b;
      cpu_pkg::ALU_SUB:  result = a - b;
      cpu_pkg::ALU_MUL:  result = a_lo * b_lo;
      cpu_pkg::ALU_SLL,
      cpu_pkg::ALU_SLLV: result = a << shamt;
      cpu_pkg::ALU_SRL,
      cpu_pkg::ALU_SRLV: result = a >> shamt;    // Logical, zero fill
      cpu_pkg::ALU_AND:  result = a & b;
      cpu_pkg::ALU_OR:   result = a | b;
      cpu_pkg::ALU_XOR:  result = a ^ b;
      cpu_pkg::ALU_NOR:  result = ~(a | b);
      cpu_pkg::ALU_SLT: begin
        result = {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      end
      cpu_pkg::ALU_SLTU: begin
        result = {{(`CPU_XLEN-1){1'b0}}, a < b};
      end
      default:           result = '0;
    endcase
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`CPU_RADDR_W-1:0] rs_addr,
  input  logic [`CPU_RADDR_W-1:0] rt_addr,
  output logic [`CPU_XLEN-1:0]    rs_data,
  output logic [`CPU_XLEN-1:0]    rt_data,
  input  logic                    wr_en,
  input  logic [`CPU_RADDR_W-1:0] wr_addr,
  input  logic [`CPU_XLEN-1:0]    wr_data
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Combinational reads, r0 hardwired
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

  // Decoder must suppress writes to r0
  a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_addr != '0);

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module instr_decoder (
  input  cpu_pkg::instr_u instr,
  output cpu_pkg::ctrl_t  ctrl
);

  logic [`CPU_XLEN-1:0]    sext_imm;
  logic [`CPU_XLEN-1:0]    zext_imm;
  logic                    zero_ext;
  logic                    writes;
  logic [`CPU_RADDR_W-1:0] dest;

  assign sext_imm = {{(`CPU_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
  assign zext_imm = {{(`CPU_XLEN-16){1'b0}}, instr.i.imm};

  // Logical immediates are zero extended
  assign zero_ext = (instr.i.opcode == `CPU_OP_ANDI) || (instr.i.opcode == `CPU_OP_ORI) ||
                    (instr.i.opcode == `CPU_OP_XORI);

  always_comb begin
    ctrl           = '0;
    ctrl.alu_op    = cpu_pkg::ALU_ADD;
    ctrl.imm_value = zero_ext ? zext_imm : sext_imm;
    writes         = 1'b0;
    dest           = instr.i.rt;
    case (instr.r.opcode)
      `CPU_OP_RTYPE: begin
        writes = 1'b1;
        dest   = instr.r.rd;
        case (instr.r.funct)
          `CPU_FN_ADD:  ctrl.alu_op = cpu_pkg::ALU_ADD;
          `CPU_FN_SUB:  ctrl.alu_op = cpu_pkg::ALU_SUB;
          `CPU_FN_MUL:  ctrl.alu_op = cpu_pkg::ALU_MUL;
          `CPU_FN_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
          `CPU_FN_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
          `CPU_FN_XOR:  ctrl.alu_op = cpu_pkg::ALU_XOR;
          `CPU_FN_NOR:  ctrl.alu_op = cpu_pkg::ALU_NOR;
          `CPU_FN_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
          `CPU_FN_SLTU: ctrl.alu_op = cpu_pkg::ALU_SLTU;
          `CPU_FN_SLL, `CPU_FN_SRL: begin
            ctrl.alu_op    = (instr.r.funct == `CPU_FN_SLL) ? cpu_pkg::ALU_SLL
                                                             : cpu_pkg::ALU_SRL;
            ctrl.src_shamt = 1'b1;
          end
          `CPU_FN_SLLV, `CPU_FN_SRLV: begin
            ctrl.alu_op    = (instr.r.funct == `CPU_FN_SLLV) ? cpu_pkg::ALU_SLLV
                                                              : cpu_pkg::ALU_SRLV;
            ctrl.shift_var = 1'b1;
          end
          default: begin
            writes       = 1'b0;
            ctrl.illegal = 1'b1;
          end
        endcase
      end
      `CPU_OP_ADDI, `CPU_OP_SLTI, `CPU_OP_SLTIU,
      `CPU_OP_ANDI, `CPU_OP_ORI, `CPU_OP_XORI: begin
        writes       = 1'b1;
        ctrl.src_imm = 1'b1;
        case (instr.i.opcode)
          `CPU_OP_SLTI:  ctrl.alu_op = cpu_pkg::ALU_SLT;
          `CPU_OP_SLTIU: ctrl.alu_op = cpu_pkg::ALU_SLTU;
          `CPU_OP_ANDI:  ctrl.alu_op = cpu_pkg::ALU_AND;
          `CPU_OP_ORI:   ctrl.alu_op = cpu_pkg::ALU_OR;
          `CPU_OP_XORI:  ctrl.alu_op = cpu_pkg::ALU_XOR;
          default:       ctrl.alu_op = cpu_pkg::ALU_ADD;   // addi
        endcase
      end
      `CPU_OP_BEQ: ctrl.is_beq  = 1'b1;
      `CPU_OP_BNE: ctrl.is_bne  = 1'b1;
      `CPU_OP_J:   ctrl.is_jump = 1'b1;
      default:     ctrl.illegal = 1'b1;
    endcase
    // r0 is never a real destination
    ctrl.reg_wr  = writes && (dest != '0);
    ctrl.wr_addr = writes ? dest : '0;
  end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 accept,
  input  cpu_pkg::instr_u      instr,
  input  cpu_pkg::ctrl_t       ctrl,
  input  logic                 rs_eq_rt,
  output logic [`CPU_XLEN-1:0] fetch_pc
);

  logic [`CPU_XLEN-1:0] seq_pc;
  logic [`CPU_XLEN-1:0] br_off;
  logic [`CPU_XLEN-1:0] br_pc;
  logic [`CPU_XLEN-1:0] jmp_pc;
  logic [`CPU_XLEN-1:0] next_pc;
  logic                 taken;

  assign seq_pc = fetch_pc + 32'd4;

  // Word offset, sign extended
  assign br_off = {{(`CPU_XLEN-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign br_pc  = seq_pc + br_off;
  assign jmp_pc = {seq_pc[`CPU_XLEN-1:28], instr.j.target, 2'b00};

  assign taken = (ctrl.is_beq & rs_eq_rt) | (ctrl.is_bne & ~rs_eq_rt);

  always_comb begin
    if (ctrl.is_jump) begin
      next_pc = jmp_pc;
    end else if (taken) begin
      next_pc = br_pc;
    end else begin
      next_pc = seq_pc;   // No delay slot
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_pc <= '0;
    end else if (accept) begin
      fetch_pc <= next_pc;
    end
  end

  // Decoder raises at most one kind of redirect
  a_one_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> $onehot0({ctrl.is_beq, ctrl.is_bne, ctrl.is_jump}));

endmodule

// ==== cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

  typedef struct packed {
    logic [5:0]              opcode;
    logic [`CPU_RADDR_W-1:0] rs;
    logic [`CPU_RADDR_W-1:0] rt;
    logic [`CPU_RADDR_W-1:0] rd;
    logic [4:0]              shamt;
    logic [5:0]              funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]              opcode;
    logic [`CPU_RADDR_W-1:0] rs;
    logic [`CPU_RADDR_W-1:0] rt;
    logic [15:0]             imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } j_fmt_t;

  // Same word, three views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_MUL, ALU_SLL, ALU_SRL, ALU_SLLV, ALU_SRLV,
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef struct packed {
    alu_op_e                 alu_op;
    logic                    src_imm;
    logic                    src_shamt;
    logic                    shift_var;   // Shift amount from rs
    logic [`CPU_XLEN-1:0]    imm_value;
    logic                    reg_wr;
    logic [`CPU_RADDR_W-1:0] wr_addr;
    logic                    is_beq;
    logic                    is_bne;
    logic                    is_jump;
    logic                    illegal;
  } ctrl_t;

  typedef struct packed {
    logic [`CPU_XLEN-1:0]    pc;
    instr_u                  instr;
    logic [`CPU_XLEN-1:0]    result;
    logic                    reg_wr;
    logic [`CPU_RADDR_W-1:0] wr_addr;
    logic                    illegal;
  } retire_t;

endpackage

// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN     32
`define CPU_NREGS    32
`define CPU_RADDR_W  5

// Primary opcodes, instr[31:26]
`define CPU_OP_RTYPE 6'h00
`define CPU_OP_J     6'h02
`define CPU_OP_BEQ   6'h04
`define CPU_OP_BNE   6'h05
`define CPU_OP_ADDI  6'h08
`define CPU_OP_SLTI  6'h0a
`define CPU_OP_SLTIU 6'h0b
`define CPU_OP_ANDI  6'h0c
`define CPU_OP_ORI   6'h0d
`define CPU_OP_XORI  6'h0e

// R-type function codes, instr[5:0]
`define CPU_FN_SLL   6'h00
`define CPU_FN_SRL   6'h02
`define CPU_FN_SLLV  6'h04
`define CPU_FN_SRLV  6'h06
`define CPU_FN_MUL   6'h18
`define CPU_FN_ADD   6'h20
`define CPU_FN_SUB   6'h22
`define CPU_FN_AND   6'h24
`define CPU_FN_OR    6'h25
`define CPU_FN_XOR   6'h26
`define CPU_FN_NOR   6'h27
`define CPU_FN_SLT   6'h2a
`define CPU_FN_SLTU  6'h2b

`endif
